//--- hdl/cpu_config.svh
// Core-wide width, register count and reset constants; include wherever widths are needed
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address width
`define CPU_XLEN 32

// Architectural register count
`define CPU_NREGS 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Byte enables per bus word
`define CPU_SEL_W 4

`endif

//--- hdl/isa_pkg.sv
// Instruction-set types shared by the decoder, ALU and core sequencer; import where needed
package isa_pkg;

  // RV32I major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } branch_e;

  // Encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    W_BYTE = 2'b00,
    W_HALF = 2'b01,
    W_WORD = 2'b10
  } width_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    src_a_pc;
    logic    src_b_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    width_e  width;
    logic    load_unsigned;
    branch_e branch;
    logic    jal;
    logic    jalr;
    logic    halt;
  } ctrl_t;

endpackage

//--- hdl/bus_pkg.sv
// Bus-side types for the request unit and its users; import where needed
package bus_pkg;

  // Who issued the current memory request
  typedef enum logic {
    OWN_FETCH = 1'b0,
    OWN_DATA  = 1'b1
  } owner_e;

  // Request unit sequence: strobe, wait for busy, wait for completion
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    WAIT_START = 2'd1,
    WAIT_DONE  = 2'd2
  } ru_state_e;

endpackage

//--- hdl/mem_req_if.sv
// Request and response channel between the core sequencer and the bus request unit
`timescale 1ns/1ps
`include "cpu_config.svh"

interface mem_req_if import bus_pkg::*; ();
  logic                  read;
  logic                  write;
  owner_e                owner;
  logic [`CPU_XLEN-1:0]  addr;
  logic [`CPU_XLEN-1:0]  wdata;
  logic [`CPU_SEL_W-1:0] sel;

  // One-cycle completion pulse, rdata valid with it
  logic                  done;
  logic [`CPU_XLEN-1:0]  rdata;

  modport core (
    output read, write, owner, addr, wdata, sel,
    input  done, rdata
  );

  modport unit (
    input  read, write, owner, addr, wdata, sel,
    output done, rdata
  );
endinterface

//--- hdl/request_unit.sv
// Bus manager that turns core memory requests into single-cycle strobes and tracks busy
`timescale 1ns/1ps
`include "cpu_config.svh"

module request_unit import bus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  mem_req_if.unit               req,
  input  logic                  busy_i,
  input  logic [`CPU_XLEN-1:0]  rdata_i,
  output logic                  read_o,
  output logic                  write_o,
  output logic [`CPU_XLEN-1:0]  adr_o,
  output logic [`CPU_SEL_W-1:0] sel_o,
  output logic [`CPU_XLEN-1:0]  wdata_o
);

  ru_state_e             state_q;
  logic                  read_q;
  logic                  write_q;
  logic [`CPU_XLEN-1:0]  adr_q;
  logic [`CPU_XLEN-1:0]  wdata_q;
  logic [`CPU_SEL_W-1:0] sel_q;
  logic                  start;
  logic                  complete;

  assign start    = (state_q == IDLE) && (req.read || req.write);
  // First low busy after the slave has acknowledged the strobe
  assign complete = (state_q == WAIT_DONE) && !busy_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else begin
      // Strobes only ever last one cycle
      read_q  <= 1'b0;
      write_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            read_q  <= req.read;
            write_q <= req.write;
            state_q <= WAIT_START;
          end
        end
        WAIT_START: if (busy_i) state_q <= WAIT_DONE;
        WAIT_DONE:  if (!busy_i) state_q <= IDLE;
        default:    state_q <= IDLE;
      endcase
    end
  end

  // Transaction fields held from the strobe until completion
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q   <= req.addr;
      sel_q   <= (req.owner == OWN_FETCH) ? '1 : req.sel;
      wdata_q <= req.wdata;
    end
  end

  assign read_o    = read_q;
  assign write_o   = write_q;
  assign adr_o     = adr_q;
  assign sel_o     = sel_q;
  assign wdata_o   = wdata_q;
  assign req.done  = complete;
  assign req.rdata = rdata_i;

endmodule

//--- hdl/decoder.sv
// Combinational RV32I-subset decoder producing control fields and the immediate
`timescale 1ns/1ps
`include "cpu_config.svh"

module decoder import isa_pkg::*; (
  input  logic [`CPU_XLEN-1:0] instr_i,
  output ctrl_t                ctrl_o,
  output logic [`CPU_XLEN-1:0] imm_o
);

  logic [2:0]           funct3;
  logic                 bit30;
  logic [`CPU_XLEN-1:0] imm_i;
  logic [`CPU_XLEN-1:0] imm_s;
  logic [`CPU_XLEN-1:0] imm_b;
  logic [`CPU_XLEN-1:0] imm_u;
  logic [`CPU_XLEN-1:0] imm_j;
  alu_op_e              arith_op;

  assign funct3 = instr_i[14:12];
  assign bit30  = instr_i[30];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Shared funct3 map for immediate and register ALU forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = bit30 ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = ALU_ADD;
    ctrl_o.width  = W_WORD;
    ctrl_o.branch = BR_NONE;
    imm_o         = imm_i;
    case (opcode_e'(instr_i[6:0]))
      OP_LUI: begin
        ctrl_o.alu_op    = ALU_PASS_B;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u;
      end
      OP_AUIPC: begin
        ctrl_o.src_a_pc  = 1'b1;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u;
      end
      OP_JAL: begin
        ctrl_o.jal       = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_j;
      end
      OP_JALR: begin
        ctrl_o.jalr      = 1'b1;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
      end
      OP_BRANCH: begin
        imm_o = imm_b;
        case (funct3)
          3'b000:  ctrl_o.branch = BR_EQ;
          3'b001:  ctrl_o.branch = BR_NE;
          3'b100:  ctrl_o.branch = BR_LT;
          3'b101:  ctrl_o.branch = BR_GE;
          3'b110:  ctrl_o.branch = BR_LTU;
          3'b111:  ctrl_o.branch = BR_GEU;
          default: ctrl_o.halt   = 1'b1;
        endcase
      end
      OP_LOAD: begin
        ctrl_o.mem_read      = 1'b1;
        ctrl_o.reg_write     = 1'b1;
        ctrl_o.src_b_imm     = 1'b1;
        ctrl_o.width         = width_e'(funct3[1:0]);
        ctrl_o.load_unsigned = funct3[2];
        ctrl_o.halt          = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      OP_STORE: begin
        ctrl_o.mem_write = 1'b1;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.width     = width_e'(funct3[1:0]);
        ctrl_o.halt      = funct3[2] || (funct3[1:0] == 2'b11);
        imm_o            = imm_s;
      end
      OP_IMM: begin
        ctrl_o.alu_op    = arith_op;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
      end
      OP_REG: begin
        ctrl_o.alu_op    = (funct3 == 3'b000 && bit30) ? ALU_SUB : arith_op;
        ctrl_o.reg_write = 1'b1;
      end
      // EBREAK, and anything unsupported, stops the core
      default: ctrl_o.halt = 1'b1;
    endcase
  end

endmodule

//--- hdl/register_file.sv
// Integer register file with two combinational read ports and one write port
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [4:0]           rs1_i,
  input  logic [4:0]           rs2_i,
  input  logic [4:0]           rd_i,
  input  logic                 we_i,
  input  logic [`CPU_XLEN-1:0] wd_i,
  output logic [`CPU_XLEN-1:0] rd1_o,
  output logic [`CPU_XLEN-1:0] rd2_o
);

  logic [`CPU_XLEN-1:0] regs_q [`CPU_NREGS];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) regs_q[i] <= '0;
    end else if (we_i && rd_i != 5'd0) begin
      regs_q[rd_i] <= wd_i;
    end
  end

  // x0 is hardwired to zero
  assign rd1_o = (rs1_i == 5'd0) ? '0 : regs_q[rs1_i];
  assign rd2_o = (rs2_i == 5'd0) ? '0 : regs_q[rs2_i];

endmodule

//--- hdl/alu.sv
// Combinational ALU with the compare flags used for branch decisions
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu import isa_pkg::*; (
  input  alu_op_e              op_i,
  input  logic [`CPU_XLEN-1:0] a_i,
  input  logic [`CPU_XLEN-1:0] b_i,
  output logic [`CPU_XLEN-1:0] result_o,
  output logic                 eq_o,
  output logic                 lt_o,
  output logic                 ltu_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];
  assign eq_o  = (a_i == b_i);
  assign lt_o  = ($signed(a_i) < $signed(b_i));
  assign ltu_o = (a_i < b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(`CPU_XLEN-1){1'b0}}, lt_o};
      ALU_SLTU:   result_o = {{(`CPU_XLEN-1){1'b0}}, ltu_o};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

//--- hdl/cpu_core.sv
// Multi-cycle core sequencer holding PC and instruction, with load/store lane handling
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core import isa_pkg::*; import bus_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 run_i,
  mem_req_if.core              mem,
  output logic [`CPU_XLEN-1:0] instr_o,
  input  ctrl_t                ctrl_i,
  input  logic [`CPU_XLEN-1:0] imm_i,
  input  logic [`CPU_XLEN-1:0] rs1_data_i,
  input  logic [`CPU_XLEN-1:0] rs2_data_i,
  output logic                 rd_we_o,
  output logic [`CPU_XLEN-1:0] rd_data_o,
  output logic [`CPU_XLEN-1:0] alu_a_o,
  output logic [`CPU_XLEN-1:0] alu_b_o,
  output alu_op_e              alu_op_o,
  input  logic [`CPU_XLEN-1:0] alu_result_i,
  input  logic                 eq_i,
  input  logic                 lt_i,
  input  logic                 ltu_i,
  output logic                 halt_o
);

  localparam int XLEN  = `CPU_XLEN;
  localparam int SEL_W = `CPU_SEL_W;

  typedef enum logic [2:0] {
    ST_IDLE, ST_FETCH, ST_EXEC, ST_MEM, ST_WB, ST_HALT
  } core_state_e;

  core_state_e     state_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] ir_q;
  logic [XLEN-1:0] res_q;
  logic [XLEN-1:0] ld_q;
  logic            take_q;
  logic            take;
  logic [1:0]      off;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] lane;
  logic [XLEN-1:0] load_ext;

  assign off      = res_q[1:0];
  assign pc_plus4 = pc_q + XLEN'(4);

  // Branch decision from the ALU compare of rs1 and rs2
  always_comb begin
    case (ctrl_i.branch)
      BR_EQ:   take = eq_i;
      BR_NE:   take = !eq_i;
      BR_LT:   take = lt_i;
      BR_GE:   take = !lt_i;
      BR_LTU:  take = ltu_i;
      BR_GEU:  take = !ltu_i;
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    if (ctrl_i.jalr)               next_pc = {res_q[XLEN-1:1], 1'b0};
    else if (ctrl_i.jal || take_q) next_pc = pc_q + imm_i;
    else                           next_pc = pc_plus4;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      pc_q    <= `CPU_RESET_PC;
    end else begin
      case (state_q)
        ST_IDLE:  if (run_i) state_q <= ST_FETCH;
        ST_FETCH: if (mem.done) state_q <= ST_EXEC;
        ST_EXEC: begin
          if (ctrl_i.halt)                            state_q <= ST_HALT;
          else if (ctrl_i.mem_read || ctrl_i.mem_write) state_q <= ST_MEM;
          else                                        state_q <= ST_WB;
        end
        ST_MEM: if (mem.done) state_q <= ST_WB;
        ST_WB: begin
          pc_q    <= next_pc;
          state_q <= run_i ? ST_FETCH : ST_IDLE;
        end
        ST_HALT: state_q <= ST_HALT;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_FETCH && mem.done) ir_q <= mem.rdata;
    if (state_q == ST_EXEC) begin
      res_q  <= alu_result_i;
      take_q <= take;
    end
    if (state_q == ST_MEM && mem.done) ld_q <= load_ext;
  end

  // Shift the addressed lane down, then extend
  assign lane = mem.rdata >> {off, 3'b000};
  always_comb begin
    case (ctrl_i.width)
      W_BYTE:  load_ext = ctrl_i.load_unsigned ? {{(XLEN-8){1'b0}}, lane[7:0]}
                                               : {{(XLEN-8){lane[7]}}, lane[7:0]};
      W_HALF:  load_ext = ctrl_i.load_unsigned ? {{(XLEN-16){1'b0}}, lane[15:0]}
                                               : {{(XLEN-16){lane[15]}}, lane[15:0]};
      default: load_ext = mem.rdata;
    endcase
  end

  assign mem.read  = (state_q == ST_FETCH) || (state_q == ST_MEM && ctrl_i.mem_read);
  assign mem.write = (state_q == ST_MEM) && ctrl_i.mem_write;
  assign mem.owner = (state_q == ST_FETCH) ? OWN_FETCH : OWN_DATA;
  assign mem.addr  = (state_q == ST_FETCH) ? pc_q : {res_q[XLEN-1:2], 2'b00};

  // Store data replicated so every lane carries it
  always_comb begin
    case (ctrl_i.width)
      W_BYTE: begin
        mem.wdata = {4{rs2_data_i[7:0]}};
        mem.sel   = SEL_W'(1) << off;
      end
      W_HALF: begin
        mem.wdata = {2{rs2_data_i[15:0]}};
        mem.sel   = SEL_W'(3) << {off[1], 1'b0};
      end
      default: begin
        mem.wdata = rs2_data_i;
        mem.sel   = '1;
      end
    endcase
  end

  assign instr_o   = ir_q;
  assign alu_a_o   = ctrl_i.src_a_pc ? pc_q : rs1_data_i;
  assign alu_b_o   = ctrl_i.src_b_imm ? imm_i : rs2_data_i;
  assign alu_op_o  = ctrl_i.alu_op;
  assign rd_we_o   = (state_q == ST_WB) && ctrl_i.reg_write;
  assign rd_data_o = (ctrl_i.jal || ctrl_i.jalr) ? pc_plus4 :
                     ctrl_i.mem_read ? ld_q : res_q;
  assign halt_o    = (state_q == ST_HALT);

endmodule

//--- hdl/team_cpu_top.sv
// Top level of the multi-cycle core, exposing the shared memory bus as plain ports
`timescale 1ns/1ps
`include "cpu_config.svh"

module team_cpu_top import isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  run_i,
  input  logic                  busy_i,
  input  logic [`CPU_XLEN-1:0]  bus_rdata_i,
  output logic [`CPU_XLEN-1:0]  bus_wdata_o,
  output logic [`CPU_XLEN-1:0]  bus_adr_o,
  output logic [`CPU_SEL_W-1:0] bus_sel_o,
  output logic                  bus_write_o,
  output logic                  bus_read_o,
  output logic                  halt_o
);

  logic [`CPU_XLEN-1:0] instr;
  ctrl_t                ctrl;
  logic [`CPU_XLEN-1:0] imm;
  logic [`CPU_XLEN-1:0] rs1_data;
  logic [`CPU_XLEN-1:0] rs2_data;
  logic                 rd_we;
  logic [`CPU_XLEN-1:0] rd_data;
  logic [`CPU_XLEN-1:0] alu_a;
  logic [`CPU_XLEN-1:0] alu_b;
  alu_op_e              alu_op;
  logic [`CPU_XLEN-1:0] alu_result;
  logic                 eq;
  logic                 lt;
  logic                 ltu;

  mem_req_if mem_if ();

  cpu_core core_i (
    .clk(clk), .rst_n_i(rst_n_i), .run_i(run_i), .mem(mem_if.core),
    .instr_o(instr), .ctrl_i(ctrl), .imm_i(imm),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rd_we_o(rd_we), .rd_data_o(rd_data),
    .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op), .alu_result_i(alu_result),
    .eq_i(eq), .lt_i(lt), .ltu_i(ltu), .halt_o(halt_o)
  );

  request_unit ru_i (
    .clk(clk), .rst_n_i(rst_n_i), .req(mem_if.unit),
    .busy_i(busy_i), .rdata_i(bus_rdata_i),
    .read_o(bus_read_o), .write_o(bus_write_o),
    .adr_o(bus_adr_o), .sel_o(bus_sel_o), .wdata_o(bus_wdata_o)
  );

  decoder dec_i (.instr_i(instr), .ctrl_o(ctrl), .imm_o(imm));

  register_file rf_i (
    .clk(clk), .rst_n_i(rst_n_i),
    .rs1_i(instr[19:15]), .rs2_i(instr[24:20]), .rd_i(instr[11:7]),
    .we_i(rd_we), .wd_i(rd_data), .rd1_o(rs1_data), .rd2_o(rs2_data)
  );

  alu alu_i (
    .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result),
    .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
  );

endmodule

//--- dv/cpu_assertions.sv
// Bus protocol checks for the request unit; attached to every request_unit through bind
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_assertions import bus_pkg::*; (
  input logic                 clk,
  input logic                 rst_n_i,
  input logic                 read_o,
  input logic                 write_o,
  input logic [`CPU_XLEN-1:0] adr_o,
  input ru_state_e            state_q
);

  // Strobes are single-cycle pulses
  strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    (read_o || write_o) |=> !(read_o || write_o))
    else $error("bus strobe lasted more than one cycle");

  read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(read_o && write_o))
    else $error("read and write strobes high together");

  // Address held from the cycle after the strobe until back in IDLE
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q != IDLE && !(read_o || write_o)) |-> $stable(adr_o))
    else $error("bus address changed before completion");

  // A strobe may only follow an idle cycle
  no_early_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
    (read_o || write_o) |-> $past(state_q) == IDLE)
    else $error("new strobe before previous transaction completed");

endmodule

//--- dv/cpu_tb.sv
// Testbench that builds a program in a bus memory model for team_cpu_top and checks every store
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

  localparam logic [31:0] DATA_BASE = 32'h0000_2000;
  localparam int          MEM_WORDS = 4096;
  localparam int          CYC_PER_INSTR = 20;

  logic        clk;
  logic        rst_n_i;
  logic        run_i;
  logic        busy_i;
  logic [31:0] bus_rdata_i;
  logic [31:0] bus_wdata_o;
  logic [31:0] bus_adr_o;
  logic [3:0]  bus_sel_o;
  logic        bus_write_o;
  logic        bus_read_o;
  logic        halt_o;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rng;
  int          pc_w;
  int          slot_off;
  int          prog_len;
  int          busy_left;
  int          m_idx;
  logic        fetched;

  // Expected stores, one entry per SW/SH/SB in program order
  logic [31:0] exp_addr[$];
  logic [3:0]  exp_sel[$];
  logic [31:0] exp_data[$];
  string       exp_name[$];

  team_cpu_top dut_i (
    .clk(clk), .rst_n_i(rst_n_i), .run_i(run_i), .busy_i(busy_i),
    .bus_rdata_i(bus_rdata_i), .bus_wdata_o(bus_wdata_o), .bus_adr_o(bus_adr_o),
    .bus_sel_o(bus_sel_o), .bus_write_o(bus_write_o), .bus_read_o(bus_read_o),
    .halt_o(halt_o)
  );

  bind request_unit cpu_assertions asrt_i (
    .clk(clk), .rst_n_i(rst_n_i), .read_o(read_o), .write_o(write_o),
    .adr_o(adr_o), .state_q(state_q)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    fail_run($sformatf("** Error %s: expected %h actual %h", name, exp, act));
  endtask

  // RV32I result rules for register and immediate ALU forms
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] word, input int boff,
                                           input logic [2:0] f3);
    logic [31:0] sh;
    sh = word >> (8 * boff);
    case (f3)
      3'd0:    return {{24{sh[7]}}, sh[7:0]};
      3'd4:    return {24'd0, sh[7:0]};
      3'd1:    return {{16{sh[15]}}, sh[15:0]};
      3'd5:    return {16'd0, sh[15:0]};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [31:0] d, input logic [3:0] sel);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) m[8*i +: 8] = sel[i] ? d[8*i +: 8] : 8'h00;
    return m;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[pc_w] = w;
    pc_w++;
  endtask

  function automatic int next_slot();
    slot_off += 4;
    return slot_off - 4;
  endfunction

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit({hi[19:0], rd, 7'b0110111});
    emit(enc_i(7'b0010011, 3'd0, rd, rd, v[11:0]));
  endtask

  // Store from rs at DATA_BASE+off; skipped-path stores are emitted but not expected
  task automatic put_store(input logic [4:0] rs, input logic [2:0] f3, input int off,
                           input logic [31:0] val, input logic expect_it, input string name);
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  sel;
    addr = DATA_BASE + 32'(off);
    emit(enc_s(f3, rs, 5'd1, 12'(off)));
    case (f3)
      3'd0: begin
        sel  = 4'b0001 << addr[1:0];
        data = {4{val[7:0]}};
      end
      3'd1: begin
        sel  = 4'b0011 << addr[1:0];
        data = {2{val[15:0]}};
      end
      default: begin
        sel  = 4'b1111;
        data = val;
      end
    endcase
    if (expect_it) begin
      exp_addr.push_back({addr[31:2], 2'b00});
      exp_sel.push_back(sel);
      exp_data.push_back(data);
      exp_name.push_back(name);
    end
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] shadow;
    logic [11:0] imm;
    logic [2:0]  br_f3 [6];
    logic [4:0]  rs_a [3];
    logic [4:0]  rs_b [3];
    int          w_off;
    int          pj;
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    rs_a  = '{5'd2, 5'd3, 5'd2};
    rs_b  = '{5'd3, 5'd2, 5'd2};
    load_const(5'd1, DATA_BASE);
    // Arithmetic on random operands
    for (int it = 0; it < 3; it++) begin
      a = next_rand();
      b = next_rand();
      load_const(5'd2, a);
      load_const(5'd3, b);
      for (int f = 0; f < 8; f++) begin
        emit(enc_r(3'(f), 7'h00, 5'd4, 5'd2, 5'd3));
        put_store(5'd4, 3'd2, next_slot(), ref_alu(3'(f), 1'b0, a, b), 1'b1, "alu_rr");
      end
      emit(enc_r(3'd0, 7'h20, 5'd4, 5'd2, 5'd3));
      put_store(5'd4, 3'd2, next_slot(), ref_alu(3'd0, 1'b1, a, b), 1'b1, "alu_sub");
      emit(enc_r(3'd5, 7'h20, 5'd4, 5'd2, 5'd3));
      put_store(5'd4, 3'd2, next_slot(), ref_alu(3'd5, 1'b1, a, b), 1'b1, "alu_sra");
      for (int f = 0; f < 9; f++) begin
        r   = next_rand();
        imm = r[11:0];
        if (f == 1 || f == 5) imm = {7'h00, r[4:0]};
        if (f == 8) imm = {7'h20, r[4:0]};
        emit(enc_i(7'b0010011, (f == 8) ? 3'd5 : 3'(f), 5'd4, 5'd2, imm));
        put_store(5'd4, 3'd2, next_slot(),
                  ref_alu((f == 8) ? 3'd5 : 3'(f), f == 8, a, {{20{imm[11]}}, imm}),
                  1'b1, "alu_ri");
      end
      r = next_rand();
      emit({r[31:12], 5'd4, 7'b0110111});
      put_store(5'd4, 3'd2, next_slot(), {r[31:12], 12'd0}, 1'b1, "lui");
      pj = pc_w * 4;
      emit({r[31:12], 5'd4, 7'b0010111});
      put_store(5'd4, 3'd2, next_slot(), 32'(pj) + {r[31:12], 12'd0}, 1'b1, "auipc");
    end
    // Byte and half stores into one word, then every load form
    w_off  = next_slot();
    shadow = next_rand();
    load_const(5'd5, shadow);
    put_store(5'd5, 3'd2, w_off, shadow, 1'b1, "store_word");
    for (int l = 0; l < 4; l++) begin
      r = next_rand();
      load_const(5'd6, r);
      put_store(5'd6, 3'd0, w_off + l, r, 1'b1, "store_byte");
      shadow[8*l +: 8] = r[7:0];
    end
    for (int l = 0; l < 4; l++) begin
      emit(enc_i(7'b0000011, 3'd0, 5'd7, 5'd1, 12'(w_off + l)));
      put_store(5'd7, 3'd2, next_slot(), ref_load(shadow, l, 3'd0), 1'b1, "load_lb");
      emit(enc_i(7'b0000011, 3'd4, 5'd7, 5'd1, 12'(w_off + l)));
      put_store(5'd7, 3'd2, next_slot(), ref_load(shadow, l, 3'd4), 1'b1, "load_lbu");
    end
    for (int h = 0; h < 2; h++) begin
      r = next_rand();
      load_const(5'd6, r);
      put_store(5'd6, 3'd1, w_off + 2 * h, r, 1'b1, "store_half");
      shadow[16*h +: 16] = r[15:0];
    end
    for (int h = 0; h < 2; h++) begin
      emit(enc_i(7'b0000011, 3'd1, 5'd7, 5'd1, 12'(w_off + 2 * h)));
      put_store(5'd7, 3'd2, next_slot(), ref_load(shadow, 2 * h, 3'd1), 1'b1, "load_lh");
      emit(enc_i(7'b0000011, 3'd5, 5'd7, 5'd1, 12'(w_off + 2 * h)));
      put_store(5'd7, 3'd2, next_slot(), ref_load(shadow, 2 * h, 3'd5), 1'b1, "load_lhu");
    end
    emit(enc_i(7'b0000011, 3'd2, 5'd7, 5'd1, 12'(w_off)));
    put_store(5'd7, 3'd2, next_slot(), shadow, 1'b1, "load_lw");
    // Branches skip one store when taken; operands a and ~a differ in sign
    a = next_rand();
    b = ~a;
    r = next_rand();
    load_const(5'd2, a);
    load_const(5'd3, b);
    load_const(5'd9, r);
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        emit(enc_b(br_f3[k], rs_a[p], rs_b[p], 13'd8));
        put_store(5'd9, 3'd2, next_slot(), r,
                  !ref_taken(br_f3[k], (p == 1) ? b : a, (p == 0) ? b : a), "branch");
      end
    end
    pj = pc_w * 4;
    emit(enc_j(5'd10, 21'd8));
    put_store(5'd9, 3'd2, next_slot(), r, 1'b0, "jal_skip");
    put_store(5'd10, 3'd2, next_slot(), 32'(pj + 4), 1'b1, "jal_link");
    // JALR base is target-3, plus 4, so bit 0 must be cleared
    pj = (pc_w + 2) * 4;
    load_const(5'd11, 32'(pj + 8 - 3));
    emit(enc_i(7'b1100111, 3'd0, 5'd12, 5'd11, 12'd4));
    put_store(5'd9, 3'd2, next_slot(), r, 1'b0, "jalr_skip");
    put_store(5'd12, 3'd2, next_slot(), 32'(pj + 4), 1'b1, "jalr_link");
    emit(32'h0010_0073);
    prog_len = pc_w;
  endtask

  // Bus slave answers each strobe with 1 to 4 busy cycles and merges writes by byte select
  always @(posedge clk) begin
    if (bus_read_o || bus_write_o) begin
      m_idx = int'(bus_adr_o[13:2]);
      if (bus_write_o) begin
        for (int i = 0; i < 4; i++)
          if (bus_sel_o[i]) mem[m_idx][8*i +: 8] = bus_wdata_o[8*i +: 8];
      end
      busy_left = 1 + int'(next_rand() % 32'd4);
      busy_i <= 1'b1;
    end else if (busy_i) begin
      busy_left--;
      if (busy_left == 0) begin
        busy_i      <= 1'b0;
        bus_rdata_i <= mem[m_idx];
      end
    end
  end

  // Store compare against the reference queue
  always @(posedge clk) begin
    if (bus_write_o) begin
      assert (exp_data.size() != 0)
        else fail_run("Error: bus write seen when no further store was expected");
      assert (bus_adr_o == exp_addr[0]) else fail_value({exp_name[0], " addr"},
                                                        exp_addr[0], bus_adr_o);
      assert (bus_sel_o == exp_sel[0]) else fail_value({exp_name[0], " sel"},
                                                       32'(exp_sel[0]), 32'(bus_sel_o));
      assert (lane_mask(bus_wdata_o, bus_sel_o) == lane_mask(exp_data[0], exp_sel[0]))
        else fail_value({exp_name[0], " data"}, lane_mask(exp_data[0], exp_sel[0]),
                        lane_mask(bus_wdata_o, bus_sel_o));
      void'(exp_addr.pop_front());
      void'(exp_sel.pop_front());
      void'(exp_data.pop_front());
      void'(exp_name.pop_front());
    end
  end

  // Run control, halt and first fetch checks
  always @(posedge clk) begin
    assert ((rst_n_i && run_i) || !halt_o)
      else fail_run("Error: halt_o high during reset or before run_i was raised");
    assert (!(bus_read_o || bus_write_o) || run_i)
      else fail_run("Error: bus strobe while run_i was low");
    assert (!(bus_read_o || bus_write_o) || !halt_o)
      else fail_run("Error: bus strobe after the core halted");
    if (bus_read_o && !fetched) begin
      assert (bus_adr_o == `CPU_RESET_PC) else fail_value("first_fetch", `CPU_RESET_PC,
                                                          bus_adr_o);
      fetched = 1'b1;
    end
  end

  initial begin
    wait (prog_len != 0);
    #(longint'(prog_len * CYC_PER_INSTR + 50) * 100);
    fail_run("Error: timeout, the core never reached halt");
  end

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    run_i       = 1'b0;
    busy_i      = 1'b0;
    bus_rdata_i = '0;
    fetched     = 1'b0;
    busy_left   = 0;
    m_idx       = 0;
    rng         = 32'd1869;
    pc_w        = 0;
    slot_off    = 0;
    prog_len    = 0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = {i[15:0], ~i[15:0]};
    build_program();
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    // Idle with run low so no strobe may appear
    repeat (6) @(posedge clk);
    run_i <= 1'b1;
    while (!halt_o) @(posedge clk);
    repeat (10) @(posedge clk);
    if (exp_data.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_run($sformatf("Error: core halted with %0d stores still missing",
                         exp_data.size()));
    end
  end

endmodule

//--- all.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/mem_req_if.sv
hdl/request_unit.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/cpu_core.sv
hdl/team_cpu_top.sv
dv/cpu_assertions.sv
dv/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

if ! verilator --binary --timing --assert -f all.f --top-module cpu_tb -o cpu_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "\*\* FAIL \*\*" "$LOG"; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
if ! grep -q "\*\* PASS \*\*" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0
